// ==== source/index_gen_pkg.sv ====
// --------------------------------------------------
// Shared widths and types for the index generator
// Generator state enum
// Configuration word and memory request structs
// --------------------------------------------------

`default_nettype none

package index_gen_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    parameter int ADDR_W  = 32;
    parameter int INDEX_W = 32;
    parameter int SHIFT_W = 5;

    // --------------------------------------------------
    // Generator states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        RESET          = 3'd0,
        IDLE           = 3'd1,
        REQUEST_CONFIG = 3'd2,
        WAIT_CONFIG    = 3'd3,
        BUSY           = 3'd4,
        PAUSE          = 3'd5,
        DRAIN          = 3'd6,
        DONE           = 3'd7
    } gen_state_t;

    // --------------------------------------------------
    // Configuration word
    // --------------------------------------------------
    typedef struct packed {
        logic               valid;
        logic [ADDR_W-1:0]  array_pointer;
        logic [INDEX_W-1:0] index_start;
        logic [INDEX_W-1:0] index_end;
        logic [INDEX_W-1:0] stride;
        // Set shifts the index left, clear shifts it right
        logic               shift_left;
        logic [SHIFT_W-1:0] shift_amount;
    } gen_config_t;

    // --------------------------------------------------
    // Memory requests
    // --------------------------------------------------
    // What one FIFO entry holds
    typedef struct packed {
        logic [ADDR_W-1:0]  address;
        logic [INDEX_W-1:0] index;
    } request_payload_t;

    typedef struct packed {
        logic             valid;
        request_payload_t payload;
    } mem_request_t;

endpackage : index_gen_pkg

`default_nettype wire

// ==== source/index_gen_fsm.sv ====
// --------------------------------------------------
// Job state machine of the index generator
// Sequences config request, generation, pause on
// FIFO pressure, drain and completion
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module index_gen_fsm import index_gen_pkg::*; (
    input  wire logic ap_clk,
    input  wire logic areset_generator,
    input  wire logic start,
    input  wire logic config_valid,
    input  wire logic at_end,
    input  wire logic almost_full,
    input  wire logic empty,
    output logic      config_request,
    output logic      load,
    output logic      advance,
    output logic      done
);

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    gen_state_t current_state;
    gen_state_t next_state;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= IDLE;
        end else begin
            current_state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = current_state;
        case (current_state)
            RESET: begin
                next_state = IDLE;
            end
            IDLE: begin
                if (start) begin
                    next_state = REQUEST_CONFIG;
                end
            end
            // Config request is a single-cycle pulse
            REQUEST_CONFIG: begin
                next_state = WAIT_CONFIG;
            end
            WAIT_CONFIG: begin
                if (config_valid) begin
                    next_state = BUSY;
                end
            end
            BUSY: begin
                // End of range wins over FIFO pressure
                if (at_end) begin
                    next_state = DRAIN;
                end else if (almost_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!almost_full) begin
                    next_state = BUSY;
                end
            end
            // Wait until the consumer has taken every request
            DRAIN: begin
                if (empty) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                if (start) begin
                    next_state = REQUEST_CONFIG;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // --------------------------------------------------
    // Control decode
    // --------------------------------------------------
    always_comb begin
        config_request = (current_state == REQUEST_CONFIG);
        load           = (current_state == WAIT_CONFIG) && config_valid;
        advance        = (current_state == BUSY) && !at_end && !almost_full;
        done           = (current_state == DONE);
    end

endmodule : index_gen_fsm

`default_nettype wire

// ==== source/index_counter.sv ====
// --------------------------------------------------
// Strided index counter
// Loads the start index, steps by the stride and
// flags the end of the range
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module index_counter import index_gen_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_generator,
    input  wire logic               load,
    input  wire logic               advance,
    input  wire logic [INDEX_W-1:0] start_index,
    input  wire logic [INDEX_W-1:0] end_index,
    input  wire logic [INDEX_W-1:0] stride,
    output logic      [INDEX_W-1:0] count,
    output logic                    at_end
);

    // Range limits held for the whole job
    logic [INDEX_W-1:0] end_reg;
    logic [INDEX_W-1:0] stride_reg;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            count <= '0;
        end else if (load) begin
            count <= start_index;
        end else if (advance) begin
            count <= count + stride_reg;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (load) begin
            end_reg    <= end_index;
            stride_reg <= stride;
        end
    end

    // Reached or passed the end, also covers start >= end
    assign at_end = (count >= end_reg);

endmodule : index_counter

`default_nettype wire

// ==== source/request_builder.sv ====
// --------------------------------------------------
// Request builder
// Latches pointer and shift settings, then forms
// one registered address/index request per advance
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module request_builder import index_gen_pkg::*; (
    input  wire logic               ap_clk,
    input  wire logic               areset_generator,
    input  wire logic               load,
    input  wire logic               advance,
    input  wire gen_config_t        config_in,
    input  wire logic [INDEX_W-1:0] count,
    output mem_request_t            push_request
);

    // --------------------------------------------------
    // Job settings
    // --------------------------------------------------
    logic [ADDR_W-1:0]  array_pointer;
    logic               shift_left;
    logic [SHIFT_W-1:0] shift_amount;

    always_ff @(posedge ap_clk) begin
        if (load) begin
            array_pointer <= config_in.array_pointer;
            shift_left    <= config_in.shift_left;
            shift_amount  <= config_in.shift_amount;
        end
    end

    // --------------------------------------------------
    // Address forming
    // --------------------------------------------------
    logic [INDEX_W-1:0] offset;
    request_payload_t   payload_comb;

    always_comb begin
        if (shift_left) begin
            offset = count << shift_amount;
        end else begin
            offset = count >> shift_amount;
        end
        payload_comb.address = array_pointer + ADDR_W'(offset);
        payload_comb.index   = count;
    end

    // --------------------------------------------------
    // Output register, one cycle after advance
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push_request.valid <= 1'b0;
        end else begin
            push_request.valid <= advance;
        end
    end

    always_ff @(posedge ap_clk) begin
        push_request.payload <= payload_comb;
    end

endmodule : request_builder

`default_nettype wire

// ==== source/request_fifo.sv ====
// --------------------------------------------------
// Synchronous request FIFO
// Circular buffer with occupancy count, almost-full
// flag and show-ahead output
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module request_fifo import index_gen_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  wire logic         ap_clk,
    input  wire logic         areset_generator,
    input  wire mem_request_t push_request,
    input  wire logic         request_pop,
    output mem_request_t      request_out,
    output logic              almost_full,
    output logic              empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    request_payload_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full  = (occupancy == CNT_W'(FIFO_DEPTH));
    assign empty = (occupancy == '0);
    assign wr_en = push_request.valid && !full;
    // Pop on an empty queue is ignored
    assign rd_en = request_pop && !empty;

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_request.payload;
        end
    end

    // Depth need not be a power of two, so wrap explicitly
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            occupancy <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign almost_full = (occupancy >= CNT_W'(PROG_THRESH));

    // Show-ahead head of queue
    assign request_out.valid   = !empty;
    assign request_out.payload = mem[rd_ptr];

endmodule : request_fifo

`default_nettype wire

// ==== source/index_gen_top.sv ====
// --------------------------------------------------
// Index generator top level
// State machine, strided counter, request builder
// and request FIFO
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module index_gen_top import index_gen_pkg::*; #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 12
) (
    input  wire logic        ap_clk,
    input  wire logic        areset_generator,
    input  wire logic        start,
    input  wire gen_config_t config_in,
    input  wire logic        request_pop,
    output logic             config_request,
    output mem_request_t     request_out,
    output logic             done
);

    // --------------------------------------------------
    // Internal control and data
    // --------------------------------------------------
    logic               load;
    logic               advance;
    logic               at_end;
    logic               almost_full;
    logic               empty;
    logic [INDEX_W-1:0] count;
    mem_request_t       push_request;

    index_gen_fsm index_gen_fsm_inst (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .config_valid    (config_in.valid),
        .at_end          (at_end),
        .almost_full     (almost_full),
        .empty           (empty),
        .config_request  (config_request),
        .load            (load),
        .advance         (advance),
        .done            (done)
    );

    index_counter index_counter_inst (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .load            (load),
        .advance         (advance),
        .start_index     (config_in.index_start),
        .end_index       (config_in.index_end),
        .stride          (config_in.stride),
        .count           (count),
        .at_end          (at_end)
    );

    request_builder request_builder_inst (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .load            (load),
        .advance         (advance),
        .config_in       (config_in),
        .count           (count),
        .push_request    (push_request)
    );

    request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) request_fifo_inst (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push_request    (push_request),
        .request_pop     (request_pop),
        .request_out     (request_out),
        .almost_full     (almost_full),
        .empty           (empty)
    );

endmodule : index_gen_top

`default_nettype wire

// ==== verif/index_gen_tb.sv ====
// --------------------------------------------------
// Index generator testbench
// Stimulus table, reference model, random and
// stalled consumer, checks and cycle timeout
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module index_gen_tb import index_gen_pkg::*; ();

    localparam int FIFO_DEPTH   = 16;
    localparam int PROG_THRESH  = 12;
    localparam int NUM_TESTS    = 7;
    localparam int STALL_CYCLES = 40;

    localparam logic [1:0] POP_ALWAYS = 2'd0;
    localparam logic [1:0] POP_RANDOM = 2'd1;
    localparam logic [1:0] POP_STALL  = 2'd2;

    // One stimulus row
    typedef struct packed {
        logic [ADDR_W-1:0]  pointer;
        logic [INDEX_W-1:0] first;
        logic [INDEX_W-1:0] last;
        logic [INDEX_W-1:0] stride;
        logic               shift_left;
        logic [SHIFT_W-1:0] shift_amount;
        logic [1:0]         pop_mode;
    } test_row_t;

    logic         ap_clk;
    logic         areset_generator;
    logic         start;
    gen_config_t  config_in;
    logic         request_pop;
    logic         config_request;
    mem_request_t request_out;
    logic         done;

    test_row_t        table_rows [NUM_TESTS];
    string            test_names [NUM_TESTS];
    request_payload_t expected_q [$];
    request_payload_t got_q [$];

    integer seed = 32'h30f572c3;
    int     error_count;
    int     check_count;
    int     failed_tests;
    int     cycle_count;
    int     timeout_limit;

    index_gen_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) index_gen_top_inst (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .config_in       (config_in),
        .request_pop     (request_pop),
        .config_request  (config_request),
        .request_out     (request_out),
        .done            (done)
    );

    always #50 ap_clk = ~ap_clk;

    // Abort once the cycle budget is spent
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: run did not complete within %0d clock cycles", timeout_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check_value(input string label, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", label, expected, actual);
        end
    endtask

    task automatic fill_table();
        table_rows[0] = '{32'h1000_0000, 32'd0, 32'd8, 32'd1, 1'b1, 5'd2, POP_ALWAYS};
        test_names[0] = "stride1_shift_left";
        table_rows[1] = '{32'h2000_0400, 32'd5, 32'd40, 32'd3, 1'b1, 5'd3, POP_RANDOM};
        test_names[1] = "stride3_shift_left";
        table_rows[2] = '{32'h0000_8000, 32'd100, 32'd130, 32'd1, 1'b0, 5'd1, POP_RANDOM};
        test_names[2] = "stride1_shift_right";
        table_rows[3] = '{32'h3000_0000, 32'd20, 32'd20, 32'd1, 1'b1, 5'd0, POP_ALWAYS};
        test_names[3] = "empty_range";
        table_rows[4] = '{32'h4000_0000, 32'd0, 32'd40, 32'd2, 1'b1, 5'd4, POP_STALL};
        test_names[4] = "long_stall";
        table_rows[5] = '{32'h5000_0000, 32'd50, 32'd10, 32'd2, 1'b0, 5'd3, POP_ALWAYS};
        test_names[5] = "start_past_end";
        table_rows[6] = '{32'h6000_1000, 32'd3, 32'd64, 32'd3, 1'b0, 5'd2, POP_RANDOM};
        test_names[6] = "stride3_shift_right";
    endtask

    // Reference model: indices from start while below end
    task automatic build_expected(input test_row_t row);
        logic [INDEX_W-1:0] idx;
        logic [INDEX_W-1:0] offset;
        request_payload_t   entry;
        expected_q.delete();
        idx = row.first;
        while (idx < row.last) begin
            if (row.shift_left) begin
                offset = idx << row.shift_amount;
            end else begin
                offset = idx >> row.shift_amount;
            end
            entry.address = row.pointer + offset;
            entry.index   = idx;
            expected_q.push_back(entry);
            idx = idx + row.stride;
        end
    endtask

    task automatic drive_config(input test_row_t row);
        config_in.array_pointer = row.pointer;
        config_in.index_start   = row.first;
        config_in.index_end     = row.last;
        config_in.stride        = row.stride;
        config_in.shift_left    = row.shift_left;
        config_in.shift_amount  = row.shift_amount;
        config_in.valid         = 1'b1;
    endtask

    // --------------------------------------------------
    // One job per table row, entered on a falling edge
    // --------------------------------------------------
    task automatic run_row(input int r);
        test_row_t row;
        string     name;
        int        errors_before;
        int        stall_left;
        int        max_occupancy;
        integer    rand_word;
        logic      pop_now;
        row           = table_rows[r];
        name          = test_names[r];
        errors_before = error_count;
        stall_left    = (row.pop_mode == POP_STALL) ? STALL_CYCLES : 0;
        max_occupancy = 0;
        build_expected(row);
        got_q.delete();

        start = 1'b1;
        @(negedge ap_clk);
        start = 1'b0;
        check_value({name, " config_request high"}, 64'd1, 64'(config_request));
        check_value({name, " done after start"}, 64'd0, 64'(done));
        @(negedge ap_clk);
        check_value({name, " config_request one cycle"}, 64'd0, 64'(config_request));
        @(negedge ap_clk);
        drive_config(row);
        @(negedge ap_clk);
        config_in.valid = 1'b0;

        // Consumer loop, a request is taken when valid and pop meet
        while (done !== 1'b1) begin
            case (row.pop_mode)
                POP_RANDOM: begin
                    rand_word = $random(seed);
                    pop_now   = rand_word[0];
                end
                POP_STALL: begin
                    pop_now = (stall_left == 0);
                    if (stall_left > 0) begin
                        stall_left--;
                    end
                end
                default: begin
                    pop_now = 1'b1;
                end
            endcase
            request_pop = pop_now;
            if (request_out.valid && pop_now) begin
                got_q.push_back(request_out.payload);
            end
            if (int'(index_gen_top_inst.request_fifo_inst.occupancy) > max_occupancy) begin
                max_occupancy = int'(index_gen_top_inst.request_fifo_inst.occupancy);
            end
            check_value({name, " config_request idle"}, 64'd0, 64'(config_request));
            @(negedge ap_clk);
        end
        request_pop = 1'b0;

        check_value({name, " request count"}, 64'(expected_q.size()), 64'(got_q.size()));
        foreach (got_q[k]) begin
            if (k < expected_q.size()) begin
                check_value($sformatf("%s index %0d", name, k),
                            64'(expected_q[k].index), 64'(got_q[k].index));
                check_value($sformatf("%s address %0d", name, k),
                            64'(expected_q[k].address), 64'(got_q[k].address));
            end
        end
        // Stall fills to the threshold plus the one in-flight item
        if (row.pop_mode == POP_STALL) begin
            check_value({name, " peak occupancy"}, 64'(PROG_THRESH + 1), 64'(max_occupancy));
        end

        repeat (3) begin
            @(negedge ap_clk);
            check_value({name, " done held"}, 64'd1, 64'(done));
            check_value({name, " queue empty"}, 64'd0, 64'(request_out.valid));
        end

        if (error_count == errors_before) begin
            $display("[PASS] %s: %0d requests", name, got_q.size());
        end else begin
            failed_tests++;
            $display("[FAIL] %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        start            = 1'b0;
        config_in        = '0;
        request_pop      = 1'b0;
        error_count      = 0;
        check_count      = 0;
        failed_tests     = 0;
        cycle_count      = 0;
        timeout_limit    = 0;
        fill_table();
        for (int r = 0; r < NUM_TESTS; r++) begin
            build_expected(table_rows[r]);
            timeout_limit += 4 * expected_q.size() + 50;
        end

        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_generator = 1'b0;
        check_value("reset config_request", 64'd0, 64'(config_request));
        check_value("reset request valid", 64'd0, 64'(request_out.valid));
        check_value("reset done", 64'd0, 64'(done));

        for (int r = 0; r < NUM_TESTS; r++) begin
            run_row(r);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : index_gen_tb

`default_nettype wire

// ==== tb.f ====
source/index_gen_pkg.sv
source/index_gen_fsm.sv
source/index_counter.sv
source/request_builder.sv
source/request_fifo.sv
source/index_gen_top.sv
verif/index_gen_tb.sv

// ==== Makefile ====
# Verilator flow for the index generator testbench

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= index_gen_tb
RTL_TOP   ?= index_gen_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
